/* compile.f */
verilog/wcmp_pkg.sv
verilog/wcmp_wb_regs.sv
verilog/wcmp_sum_engine.sv
verilog/wcmp_result.sv
verilog/wcmp_top.sv
testbench/wcmp_props.sv
testbench/tb_wcmp.sv

/* run.sh */
#!/bin/sh
# builds tb_wcmp with Verilator, runs it, and looks for the pass line in sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tb_wcmp -f compile.f \
    -o sim_wcmp > build.log 2>&1 \
    && ./obj_dir/sim_wcmp +verilator+error+limit+1000 > sim.log 2>&1
grep -q '^TEST PASS$' sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* testbench/tb_wcmp.sv */
// self-checking testbench for wcmp_top; LCG stimulus, STATUS polled with bounded loops
module tb_wcmp;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 40;
    localparam int NUM_JOBS   = 200;
    localparam int VW         = wcmp_pkg::VEC_WIDTH;

    logic              clk;
    logic              rst;
    wcmp_pkg::wb_req_t wb_in;
    wcmp_pkg::wb_rsp_t wb_out;
    logic              irq;
    logic [31:0]       seed;
    int                checks;
    int                errors;
    int                err_mark;
    int                tests;
    int                bad_tests;
    logic              stalled;
    string             stall_msg;

    wcmp_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_in  (wb_in),
        .wb_out (wb_out),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ends the run when a bounded wait gives up
    initial begin
        wait (stalled);
        $display("%s", stall_msg);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [VW-1:0] rand_vec();
        logic [31:0] r;
        r = lcg_next();
        return r[31 -: VW];
    endfunction

    function automatic wcmp_pkg::wcmp_job_t rand_job();
        wcmp_pkg::wcmp_job_t j;
        j.vec_a  = rand_vec();
        j.vec_b  = rand_vec();
        j.weight = rand_vec();
        return j;
    endfunction

    // count positions set in both the vector and the weight
    function automatic wcmp_pkg::wcmp_sums_t model_sums(wcmp_pkg::wcmp_job_t j);
        wcmp_pkg::wcmp_sums_t s;
        s = '0;
        for (int i = 0; i < VW; i++) begin
            if (j.weight[i]) begin
                s.sum_a = s.sum_a + wcmp_pkg::SUM_WIDTH'(j.vec_a[i]);
                s.sum_b = s.sum_b + wcmp_pkg::SUM_WIDTH'(j.vec_b[i]);
            end
        end
        return s;
    endfunction

    function automatic wcmp_pkg::wcmp_status_t model_status(wcmp_pkg::wcmp_sums_t s,
                                                            logic done);
        wcmp_pkg::wcmp_status_t st;
        st.busy = 1'b0;
        st.done = done;
        st.gt   = s.sum_a > s.sum_b;
        st.eq   = s.sum_a == s.sum_b;
        st.lt   = s.sum_a < s.sum_b;
        return st;
    endfunction

    function automatic wcmp_pkg::wcmp_status_t to_status(logic [31:0] r);
        wcmp_pkg::wcmp_status_t st;
        st.busy = r[0];
        st.done = r[1];
        st.gt   = r[2];
        st.eq   = r[3];
        st.lt   = r[4];
        return st;
    endfunction

    function automatic wcmp_pkg::wcmp_sums_t to_sums(logic [31:0] r);
        wcmp_pkg::wcmp_sums_t s;
        s.sum_a = r[4:0];
        s.sum_b = r[12:8];
        return s;
    endfunction

    task automatic check_sums(string name, wcmp_pkg::wcmp_sums_t exp,
                              wcmp_pkg::wcmp_sums_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected a=%0d b=%0d got a=%0d b=%0d", $time,
                     name, exp.sum_a, exp.sum_b, act.sum_a, act.sum_b);
        end
    endtask

    task automatic check_status(string name, wcmp_pkg::wcmp_status_t exp,
                                wcmp_pkg::wcmp_status_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected busy,done,gt,eq,lt=%b got %b",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // one Wishbone classic cycle, read data taken while ack is high
    task automatic bus_xfer(input logic we, input logic [wcmp_pkg::ADR_WIDTH-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
        wcmp_pkg::wb_req_t req;
        logic              got;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        got     = 1'b0;
        rdat    = '0;
        @(posedge clk);
        wb_in <= req;
        for (int n = 0; n < ACK_LIMIT && !got; n++) begin
            @(negedge clk);
            if (wb_out.ack) begin
                got  = 1'b1;
                rdat = wb_out.dat;
            end
        end
        if (!got) begin
            stall_msg = $sformatf("bus request to address %0d never got an ack", adr);
            stalled   = 1'b1;
        end
        @(posedge clk);
        wb_in <= '0;
    endtask

    task automatic bus_write(logic [wcmp_pkg::ADR_WIDTH-1:0] adr, logic [31:0] dat);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [wcmp_pkg::ADR_WIDTH-1:0] adr,
                            output logic [31:0] dat);
        bus_xfer(1'b0, adr, '0, dat);
    endtask

    task automatic poll_status(int bit_idx, string what);
        logic [31:0] r;
        logic        seen;
        seen = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !seen; n++) begin
            bus_read(wcmp_pkg::ADR_STATUS, r);
            seen = r[bit_idx];
        end
        if (!seen) begin
            stall_msg = $sformatf("%s never read high in STATUS", what);
            stalled   = 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic start_job(wcmp_pkg::wcmp_job_t j);
        bus_write(wcmp_pkg::ADR_STATUS, 32'(1) << wcmp_pkg::STATUS_CLR_BIT);
        bus_write(wcmp_pkg::ADR_VEC_A, 32'(j.vec_a));
        bus_write(wcmp_pkg::ADR_VEC_B, 32'(j.vec_b));
        bus_write(wcmp_pkg::ADR_WEIGHT, 32'(j.weight));
        bus_write(wcmp_pkg::ADR_CTRL, 32'(1) << wcmp_pkg::CTRL_START_BIT);
    endtask

    task automatic finish_job(wcmp_pkg::wcmp_job_t j, string name);
        wcmp_pkg::wcmp_sums_t exp;
        logic [31:0]          r;
        exp = model_sums(j);
        poll_status(1, "done");
        bus_read(wcmp_pkg::ADR_SUMS, r);
        check_sums({name, " sums"}, exp, to_sums(r));
        bus_read(wcmp_pkg::ADR_STATUS, r);
        check_status({name, " status"}, model_status(exp, 1'b1), to_status(r));
    endtask

    task automatic run_job(wcmp_pkg::wcmp_job_t j, string name);
        start_job(j);
        finish_job(j, name);
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors != err_mark) begin
            bad_tests++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end else begin
            $display("test %s: passed", name);
        end
        err_mark = errors;
    endtask

    initial begin
        wcmp_pkg::wcmp_job_t j;
        logic [31:0]         r;
        logic [VW-1:0]       v;
        seed      = 32'h50d4;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        tests     = 0;
        bad_tests = 0;
        stalled   = 1'b0;
        rst       = 1'b1;
        wb_in     = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        bus_read(wcmp_pkg::ADR_STATUS, r);
        check_status("status after reset", '0, to_status(r));
        bus_read(wcmp_pkg::ADR_SUMS, r);
        check_sums("sums after reset", '0, to_sums(r));
        @(negedge clk);
        check_bit("irq after reset", 1'b0, irq);
        repeat (4) begin
            // VEC_A, VEC_B and WEIGHT sit at addresses 0 to 2
            for (int k = 0; k < 3; k++) begin
                v = rand_vec();
                bus_write(3'(k), 32'(v));
                bus_read(3'(k), r);
                check_word($sformatf("register %0d", k), 32'(v), r);
            end
        end
        end_test("register readback");

        repeat (NUM_JOBS) begin
            j = rand_job();
            if ((lcg_next() >> 30) == 0) begin
                j.vec_b = j.vec_a;
            end
            run_job(j, "random job");
        end
        end_test("random jobs");

        repeat (8) begin
            j = rand_job();
            j.weight = '0;
            run_job(j, "zero weight");
            j.weight = '1;
            run_job(j, "all-ones weight");
            j.weight = rand_vec();
            j.vec_b  = j.vec_a;
            run_job(j, "equal vectors");
        end
        end_test("edge weights");

        repeat (4) begin
            j = rand_job();
            run_job(j, "done flag");
            @(negedge clk);
            check_bit("irq after done", 1'b1, irq);
            bus_write(wcmp_pkg::ADR_STATUS, 32'(1) << wcmp_pkg::STATUS_CLR_BIT);
            bus_read(wcmp_pkg::ADR_STATUS, r);
            check_status("status after clear", model_status(model_sums(j), 1'b0),
                         to_status(r));
            @(negedge clk);
            check_bit("irq after clear", 1'b0, irq);
            bus_read(wcmp_pkg::ADR_SUMS, r);
            check_sums("sums after clear", model_sums(j), to_sums(r));
        end
        end_test("done flag and interrupt");

        repeat (10) begin
            j = rand_job();
            start_job(j);
            poll_status(0, "busy");
            // new operands and a second start land while the engine runs
            bus_write(wcmp_pkg::ADR_VEC_A, 32'(rand_vec()));
            bus_write(wcmp_pkg::ADR_VEC_B, 32'(rand_vec()));
            bus_write(wcmp_pkg::ADR_CTRL, 32'(1) << wcmp_pkg::CTRL_START_BIT);
            finish_job(j, "start while busy");
        end
        end_test("start while busy");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, bad_tests, checks, errors, u_dut.u_props.err_cnt);
        if (errors == 0 && u_dut.u_props.err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/wcmp_props.sv */
// bus and engine protocol checks, bound into wcmp_top; err_cnt counts failed assertions
module wcmp_props (
    input logic                   clk,
    input logic                   rst,
    input wcmp_pkg::wb_req_t      wb_in,
    input wcmp_pkg::wb_rsp_t      wb_out,
    input logic                   irq,
    input wcmp_pkg::wcmp_status_t status,
    input logic                   busy
);
    timeunit 1ns;
    timeprecision 1ps;

    int         err_cnt = 0;
    logic [5:0] busy_run;

    // consecutive busy cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_run <= '0;
        end else if (busy) begin
            busy_run <= busy_run + 6'd1;
        end else begin
            busy_run <= '0;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_out.ack |=> !wb_out.ack)
        else begin
            $error("ack high on two consecutive clocks");
            err_cnt++;
        end

    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        wb_out.ack |-> $past(wb_in.cyc && wb_in.stb))
        else begin
            $error("ack without a request on the previous clock");
            err_cnt++;
        end

    irq_is_done: assert property (@(posedge clk) disable iff (rst)
        irq == status.done)
        else begin
            $error("irq differs from the stored done flag");
            err_cnt++;
        end

    busy_bounded: assert property (@(posedge clk) disable iff (rst)
        busy_run <= 6'(wcmp_pkg::VEC_WIDTH))
        else begin
            $error("engine busy longer than one pass over the vector");
            err_cnt++;
        end

endmodule

bind wcmp_top wcmp_props u_props (
    .clk    (clk),
    .rst    (rst),
    .wb_in  (wb_in),
    .wb_out (wb_out),
    .irq    (irq),
    .status (status),
    .busy   (busy)
);

/* verilog/wcmp_top.sv */
// weighted comparator peripheral; single Wishbone classic slave, level irq on done
module wcmp_top (
    input  logic              clk,
    input  logic              rst,
    input  wcmp_pkg::wb_req_t wb_in,
    output wcmp_pkg::wb_rsp_t wb_out,
    output logic              irq
);

    wcmp_pkg::wcmp_job_t    job;
    wcmp_pkg::wcmp_sums_t   eng_sums;
    wcmp_pkg::wcmp_sums_t   res_sums;
    wcmp_pkg::wcmp_status_t status;
    logic                   start;
    logic                   clear_done;
    logic                   busy;
    logic                   eng_done;

    // bus side
    wcmp_wb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_in      (wb_in),
        .status     (status),
        .sums       (res_sums),
        .wb_out     (wb_out),
        .job        (job),
        .start      (start),
        .clear_done (clear_done)
    );

    wcmp_sum_engine u_engine (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .job   (job),
        .busy  (busy),
        .done  (eng_done),
        .sums  (eng_sums)
    );

    // stored outcome and interrupt
    wcmp_result u_result (
        .clk        (clk),
        .rst        (rst),
        .done_in    (eng_done),
        .busy       (busy),
        .sums_in    (eng_sums),
        .clear_done (clear_done),
        .sums       (res_sums),
        .status     (status),
        .irq        (irq)
    );

endmodule

/* verilog/wcmp_result.sv */
// result store; done wins over a clear arriving in the same clock
module wcmp_result (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   done_in,
    input  logic                   busy,
    input  wcmp_pkg::wcmp_sums_t   sums_in,
    input  logic                   clear_done,
    output wcmp_pkg::wcmp_sums_t   sums,
    output wcmp_pkg::wcmp_status_t status,
    output logic                   irq
);

    logic done_q;
    logic gt_q;
    logic eq_q;
    logic lt_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sums   <= '0;
            done_q <= 1'b0;
            gt_q   <= 1'b0;
            eq_q   <= 1'b0;
            lt_q   <= 1'b0;
        end else if (done_in) begin
            sums   <= sums_in;
            done_q <= 1'b1;
            gt_q   <= (sums_in.sum_a > sums_in.sum_b);
            eq_q   <= (sums_in.sum_a == sums_in.sum_b);
            lt_q   <= (sums_in.sum_a < sums_in.sum_b);
        end else if (clear_done) begin
            // outcome and sums stay for readback
            done_q <= 1'b0;
        end
    end

    assign status.busy = busy;
    assign status.done = done_q;
    assign status.gt   = gt_q;
    assign status.eq   = eq_q;
    assign status.lt   = lt_q;

    // level interrupt
    assign irq = done_q;

endmodule

/* verilog/wcmp_sum_engine.sv */
// serial weighted sums of both vectors, one bit position per clock; start ignored while busy
module wcmp_sum_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  wcmp_pkg::wcmp_job_t  job,
    output logic                 busy,
    output logic                 done,
    output wcmp_pkg::wcmp_sums_t sums
);

    wcmp_pkg::wcmp_job_t            job_q;
    logic [wcmp_pkg::CNT_WIDTH-1:0] cnt;
    logic [wcmp_pkg::SUM_WIDTH-1:0] acc_a;
    logic [wcmp_pkg::SUM_WIDTH-1:0] acc_b;
    logic [wcmp_pkg::SUM_WIDTH-1:0] nxt_a;
    logic [wcmp_pkg::SUM_WIDTH-1:0] nxt_b;
    logic                           bit_a;
    logic                           bit_b;
    logic                           last;

    // a bit counts only where the weight is set
    assign bit_a = job_q.vec_a[cnt] & job_q.weight[cnt];
    assign bit_b = job_q.vec_b[cnt] & job_q.weight[cnt];

    assign nxt_a = acc_a + wcmp_pkg::SUM_WIDTH'(bit_a);
    assign nxt_b = acc_b + wcmp_pkg::SUM_WIDTH'(bit_b);

    assign last = (cnt == wcmp_pkg::CNT_WIDTH'(wcmp_pkg::VEC_WIDTH - 1));

    // final position folded in during the done cycle
    assign done       = busy && last;
    assign sums.sum_a = nxt_a;
    assign sums.sum_b = nxt_b;

    // busy doubles as the idle/run state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_q <= '0;
            busy  <= 1'b0;
            cnt   <= '0;
            acc_a <= '0;
            acc_b <= '0;
        end else if (!busy) begin
            if (start) begin
                job_q <= job;
                busy  <= 1'b1;
                cnt   <= '0;
                acc_a <= '0;
                acc_b <= '0;
            end
        end else begin
            acc_a <= nxt_a;
            acc_b <= nxt_b;
            cnt   <= cnt + 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* verilog/wcmp_wb_regs.sv */
// Wishbone classic slave, one ack per request; no byte selects, bursts or error responses
module wcmp_wb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  wcmp_pkg::wb_req_t      wb_in,
    input  wcmp_pkg::wcmp_status_t status,
    input  wcmp_pkg::wcmp_sums_t   sums,
    output wcmp_pkg::wb_rsp_t      wb_out,
    output wcmp_pkg::wcmp_job_t    job,
    output logic                   start,
    output logic                   clear_done
);

    logic                           ack;
    logic [wcmp_pkg::DAT_WIDTH-1:0] rd_dat;
    logic [wcmp_pkg::DAT_WIDTH-1:0] rd_mux;
    logic                           req;
    logic                           wr;
    logic                           go_pend;

    // new request seen only while ack is low
    assign req = wb_in.cyc && wb_in.stb && !ack;
    assign wr  = req && wb_in.we;

    assign wb_out.ack = ack;
    assign wb_out.dat = rd_dat;

    always_comb begin
        rd_mux = '0;
        case (wb_in.adr)
            wcmp_pkg::ADR_VEC_A: begin
                rd_mux[wcmp_pkg::VEC_WIDTH-1:0] = job.vec_a;
            end
            wcmp_pkg::ADR_VEC_B: begin
                rd_mux[wcmp_pkg::VEC_WIDTH-1:0] = job.vec_b;
            end
            wcmp_pkg::ADR_WEIGHT: begin
                rd_mux[wcmp_pkg::VEC_WIDTH-1:0] = job.weight;
            end
            wcmp_pkg::ADR_STATUS: begin
                rd_mux[4:0] = {status.lt, status.eq, status.gt, status.done, status.busy};
            end
            wcmp_pkg::ADR_SUMS: begin
                rd_mux[wcmp_pkg::SUM_WIDTH-1:0] = sums.sum_a;
                rd_mux[wcmp_pkg::SUMB_LSB +: wcmp_pkg::SUM_WIDTH] = sums.sum_b;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack        <= 1'b0;
            rd_dat     <= '0;
            job        <= '0;
            go_pend    <= 1'b0;
            start      <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            ack <= req;
            // start leaves one clock after the write is taken
            go_pend <= wr && (wb_in.adr == wcmp_pkg::ADR_CTRL)
                       && wb_in.dat[wcmp_pkg::CTRL_START_BIT];
            start <= go_pend;
            clear_done <= wr && (wb_in.adr == wcmp_pkg::ADR_STATUS)
                          && wb_in.dat[wcmp_pkg::STATUS_CLR_BIT];
            if (req && !wb_in.we) begin
                rd_dat <= rd_mux;
            end
            if (wr) begin
                case (wb_in.adr)
                    wcmp_pkg::ADR_VEC_A: begin
                        job.vec_a <= wb_in.dat[wcmp_pkg::VEC_WIDTH-1:0];
                    end
                    wcmp_pkg::ADR_VEC_B: begin
                        job.vec_b <= wb_in.dat[wcmp_pkg::VEC_WIDTH-1:0];
                    end
                    wcmp_pkg::ADR_WEIGHT: begin
                        job.weight <= wb_in.dat[wcmp_pkg::VEC_WIDTH-1:0];
                    end
                    default: begin
                        // read-only and command addresses keep no storage
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/wcmp_pkg.sv */
// shared widths, register map and bundles; 16-bit vectors with 1-bit weights only
package wcmp_pkg;

    localparam int VEC_WIDTH = 16;
    // a sum can reach VEC_WIDTH itself
    localparam int SUM_WIDTH = 5;
    localparam int CNT_WIDTH = $clog2(VEC_WIDTH);
    localparam int ADR_WIDTH = 3;
    localparam int DAT_WIDTH = 32;

    // word addresses
    localparam logic [ADR_WIDTH-1:0] ADR_VEC_A  = 3'd0;
    localparam logic [ADR_WIDTH-1:0] ADR_VEC_B  = 3'd1;
    localparam logic [ADR_WIDTH-1:0] ADR_WEIGHT = 3'd2;
    localparam logic [ADR_WIDTH-1:0] ADR_CTRL   = 3'd3;
    localparam logic [ADR_WIDTH-1:0] ADR_STATUS = 3'd4;
    localparam logic [ADR_WIDTH-1:0] ADR_SUMS   = 3'd5;

    // command bits and readback placement
    localparam int CTRL_START_BIT = 0;
    localparam int STATUS_CLR_BIT = 1;
    localparam int SUMB_LSB       = 8;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [ADR_WIDTH-1:0] adr;
        logic [DAT_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [DAT_WIDTH-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [VEC_WIDTH-1:0] vec_a;
        logic [VEC_WIDTH-1:0] vec_b;
        logic [VEC_WIDTH-1:0] weight;
    } wcmp_job_t;

    typedef struct packed {
        logic [SUM_WIDTH-1:0] sum_a;
        logic [SUM_WIDTH-1:0] sum_b;
    } wcmp_sums_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic gt;
        logic eq;
        logic lt;
    } wcmp_status_t;

endpackage
